/* eth_logger.f */
+incdir+include
hw/eth_frame_pkg.sv
hw/eth_log_pkg.sv
hw/frame_info_if.sv
hw/eth_frame_capture.sv
hw/eth_script_matcher.sv
hw/eth_frame_log_emitter.sv
hw/eth_logger_top.sv
testbench/tb_eth_logger.sv

/* testbench/tb_eth_logger.sv */
// testbench for the frame logger: random frames and scripts, reference model, checks, report
`timescale 1ns/1ps
`default_nettype none

`include "eth_logger_defines.svh"

module tb_eth_logger;
	localparam int SEED = 32'h9d67_917a;
	localparam int IDX_BITS = $clog2(`NUM_SCRIPTS);
	localparam int MAX_BEATS = `MAX_FRAME_BYTES / `LOG_BYTES;
	localparam int ADMIT_FREE = MAX_BEATS; // free words a first beat needs.
	localparam int FRAMES_TOTAL = 60;
	localparam int STALL_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = FRAMES_TOTAL * (4 * MAX_BEATS + 16) + 4 * STALL_CYCLES;
	localparam int M_IDLE = 0;
	localparam int M_HEADER = 1;
	localparam int M_FRAME = 2;
	localparam int M_DROP = 3;

	logic clk = 1'b0;
	logic rst_n;
	logic [`LOG_WIDTH-1:0] frame_data;
	logic frame_valid;
	logic frame_last;
	logic [2:0] frame_bytes;
	logic cfg_strobe;
	logic [IDX_BITS-1:0] cfg_index;
	logic cfg_enable;
	logic [`CFG_WORD_BITS-1:0] cfg_word;
	logic [`LOG_WIDTH-1:0] cfg_value;
	logic [`LOG_WIDTH-1:0] cfg_mask;
	logic [15:0] log_id;
	logic [`LOG_WIDTH-1:0] log_data;
	logic log_last;
	logic log_valid;
	logic log_ready;

	integer seed = SEED;
	integer ready_seed = SEED + 1;
	int ready_mode = 0; // 0 random, 1 held low.
	int cycles = 0;
	int err_cnt = 0;
	int test_cnt = 0;
	int test_fail = 0;
	int rec_cnt = 0;
	int refused_cnt = 0;
	int err_start;
	int rec_start;
	int ref_start;

	// model of the buffer, the matcher and the emitter.
	logic [63:0] m_cyc;
	logic [63:0] m_ts;
	logic [15:0] m_bytes;
	logic [7:0] m_idx;
	logic [`NUM_SCRIPTS-1:0] m_flags;
	bit m_in_frame;
	bit m_admit;
	int m_fill;
	int m_state;
	int m_tx;
	int m_left;
	bit pend_valid;
	bit pend_stored;
	logic [`NUM_SCRIPTS-1:0] pend_flags;
	logic [15:0] pend_size;
	logic [63:0] pend_ts;
	logic [`NUM_SCRIPTS-1:0] q_flags [$];
	logic [15:0] q_size [$];
	logic [63:0] q_ts [$];
	logic [63:0] stored_words [$];
	logic [63:0] exp_data [$];
	bit exp_last [$];
	bit s_en [`NUM_SCRIPTS];
	logic [7:0] s_word [`NUM_SCRIPTS];
	logic [63:0] s_value [`NUM_SCRIPTS];
	logic [63:0] s_mask [`NUM_SCRIPTS];
	bit prev_stall;
	logic [63:0] prev_data;
	logic prev_last;

	eth_logger_top eth_logger_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_data(frame_data),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_bytes(frame_bytes),
		.cfg_strobe(cfg_strobe),
		.cfg_index(cfg_index),
		.cfg_enable(cfg_enable),
		.cfg_word(cfg_word),
		.cfg_value(cfg_value),
		.cfg_mask(cfg_mask),
		.log_id(log_id),
		.log_data(log_data),
		.log_last(log_last),
		.log_valid(log_valid),
		.log_ready(log_ready)
	);

	always #20 clk = ~clk;

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic int word_count(input logic [15:0] size);
		return (int'(size) + `LOG_BYTES - 1) / `LOG_BYTES;
	endfunction

	// header words as the log field layout lays them out, word 0 first.
	function automatic logic [63:0] header_word(input int k, input logic [15:0] id,
			input logic [63:0] ts, input logic [15:0] size,
			input logic [`NUM_SCRIPTS-1:0] flags);
		logic [15:0] rec_len;
		rec_len = 16'd16 + 16'(word_count(size) * `LOG_BYTES);
		case (k)
			0: return {rec_len, id, `LOG_MAGIC};
			1: return ts;
			default: return {{(32-`NUM_SCRIPTS){1'b0}}, flags, size, 8'(`LOG_BYTES), `DIRECTION_ID};
		endcase
	endfunction

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles, %0d log words never arrived",
				cycles, exp_data.size());
			$display("STATUS: FAIL");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (ready_mode == 1) begin
			log_ready <= 1'b0;
		end else begin
			log_ready <= $random(ready_seed) & 1;
		end
	end

	always @(posedge clk) begin : model_step
		bit rd;
		bit wr;
		int nb;
		logic [`NUM_SCRIPTS-1:0] flags;
		logic [15:0] size;
		logic [63:0] ts;
		logic [63:0] w;
		if (!rst_n) begin
			m_cyc = '0;
			m_in_frame = 1'b0;
			m_fill = 0;
			m_state = M_IDLE;
			pend_valid = 1'b0;
			prev_stall = 1'b0;
			for (int i = 0; i < `NUM_SCRIPTS; i++) begin
				s_en[i] = 1'b0;
			end
		end else begin
			if (prev_stall) begin
				assert (log_valid === 1'b1 && log_data === prev_data && log_last === prev_last)
				else begin
					$display("FAILED %0t ns: log output changed while stalled", $time);
					err_cnt++;
				end
			end
			if (log_valid === 1'b1 && log_ready) begin
				assert (exp_data.size() != 0) else begin
					$display("log word %h arrived at %0t ns with no record expected",
						log_data, $time);
					err_cnt++;
				end
				if (exp_data.size() != 0) begin
					assert (log_data === exp_data[0] && log_last === exp_last[0]) else begin
						$display("FAILED %0t ns: log word %h last %b, expected %h last %b",
							$time, log_data, log_last, exp_data[0], exp_last[0]);
						err_cnt++;
					end
					void'(exp_data.pop_front());
					void'(exp_last.pop_front());
				end
			end
			prev_stall = (log_valid === 1'b1) && !log_ready;
			prev_data = log_data;
			prev_last = log_last;

			rd = (m_fill != 0) && ((m_state == M_FRAME && log_ready) || m_state == M_DROP);
			wr = 1'b0;
			case (m_state)
				M_IDLE: begin
					if (q_size.size() != 0) begin
						flags = q_flags.pop_front();
						size = q_size.pop_front();
						ts = q_ts.pop_front();
						m_left = word_count(size);
						m_tx = 0;
						if (flags != '0) begin
							for (int k = 0; k < 3; k++) begin
								exp_data.push_back(header_word(k, log_id, ts, size, flags));
								exp_last.push_back(1'b0);
							end
							rec_cnt++;
						end
						m_state = (flags != '0) ? M_HEADER : M_DROP;
						for (int k = 0; k < m_left; k++) begin
							w = stored_words.pop_front();
							if (flags != '0) begin
								exp_data.push_back(w);
								exp_last.push_back(k == m_left - 1);
							end
						end
					end
				end
				M_HEADER: begin
					if (log_ready) begin
						if (m_tx == 2) m_state = M_FRAME;
						else m_tx++;
					end
				end
				default: begin
					if (rd) begin
						m_left--;
						if (m_left == 0) m_state = M_IDLE;
					end
				end
			endcase
			if (pend_valid && pend_stored) begin
				q_flags.push_back(pend_flags); // refused summaries are dropped.
				q_size.push_back(pend_size);
				q_ts.push_back(pend_ts);
			end
			pend_valid = 1'b0;

			if (frame_valid) begin
				if (!m_in_frame) begin
					m_admit = (`DATA_FIFO_BEATS - m_fill) >= ADMIT_FREE;
					m_ts = m_cyc;
					m_bytes = '0;
					m_idx = '0;
					m_flags = '0;
				end
				for (int i = 0; i < `NUM_SCRIPTS; i++) begin
					if (s_en[i] && s_word[i] == m_idx
							&& (frame_data & s_mask[i]) == (s_value[i] & s_mask[i]))
						m_flags[i] = 1'b1;
				end
				if (m_admit) stored_words.push_back(frame_data);
				wr = m_admit;
				if (frame_last) begin
					nb = (frame_bytes == 3'd0) ? `LOG_BYTES : int'(frame_bytes);
					pend_valid = 1'b1;
					pend_stored = m_admit;
					pend_flags = m_flags;
					pend_size = m_bytes + 16'(nb);
					pend_ts = m_ts;
					if (!m_admit) refused_cnt++;
					m_in_frame = 1'b0;
				end else begin
					m_bytes = m_bytes + 16'(`LOG_BYTES);
					m_idx = m_idx + 8'd1;
					m_in_frame = 1'b1;
				end
			end
			if (cfg_strobe) begin
				s_en[cfg_index] = cfg_enable;
				s_word[cfg_index] = cfg_word;
				s_value[cfg_index] = cfg_value;
				s_mask[cfg_index] = cfg_mask;
			end
			m_fill = m_fill + int'(wr) - int'(rd);
			m_cyc = m_cyc + 64'd1;
		end
	end

	task automatic write_script(input int idx, input bit en, input int word,
			input logic [63:0] value, input logic [63:0] mask);
		@(posedge clk);
		cfg_strobe <= 1'b1;
		cfg_index <= IDX_BITS'(idx);
		cfg_enable <= en;
		cfg_word <= `CFG_WORD_BITS'(word);
		cfg_value <= value;
		cfg_mask <= mask;
		@(posedge clk);
		cfg_strobe <= 1'b0;
	endtask

	// zero mask, low nibble compare, or a full compare that hardly ever hits.
	task automatic random_script(input int idx);
		int kind;
		int word;
		bit en;
		logic [63:0] value;
		logic [63:0] mask;
		kind = rand_below(3);
		value = {$random(seed), $random(seed)};
		mask = {$random(seed), $random(seed)};
		if (kind == 0) mask = '0;
		if (kind == 1) begin
			mask = 64'hF;
			value = 64'(rand_below(4));
		end
		en = rand_below(4) != 0;
		word = rand_below(36); // some words lie past the longest frame.
		write_script(idx, en, word, value, mask);
	endtask

	task automatic send_frame();
		int size;
		int beats;
		int nb;
		logic [63:0] w;
		size = `MIN_FRAME_BYTES + rand_below(`MAX_FRAME_BYTES - `MIN_FRAME_BYTES + 1);
		beats = word_count(16'(size));
		for (int b = 0; b < beats; b++) begin
			while (rand_below(8) == 0) begin
				@(posedge clk);
				frame_valid <= 1'b0;
				frame_last <= 1'b0;
			end
			@(posedge clk);
			w = {$random(seed), $random(seed)};
			w[3:0] = 4'(rand_below(4));
			nb = size - b * `LOG_BYTES;
			if (b == beats - 1 && nb < `LOG_BYTES) begin
				w = w & ((64'd1 << (8 * nb)) - 64'd1);
			end
			if (b == 0) log_id <= 16'($random(seed));
			frame_data <= w;
			frame_valid <= 1'b1;
			frame_last <= (b == beats - 1);
			frame_bytes <= 3'(nb);
		end
		@(posedge clk);
		frame_valid <= 1'b0;
		frame_last <= 1'b0;
		frame_data <= '0;
		repeat (rand_below(6)) @(posedge clk);
	endtask

	task automatic start_test();
		err_start = err_cnt;
		rec_start = rec_cnt;
		ref_start = refused_cnt;
	endtask

	task automatic finish_test(input string name);
		int errs;
		repeat (2) @(posedge clk);
		while (!(q_size.size() == 0 && m_state == M_IDLE && !pend_valid && exp_data.size() == 0))
			@(posedge clk);
		repeat (4) @(posedge clk);
		errs = err_cnt - err_start;
		test_cnt++;
		if (errs != 0) test_fail++;
		$display("test %s: %0d records, %0d refused, %0d errors, %s", name,
			rec_cnt - rec_start, refused_cnt - ref_start, errs, (errs == 0) ? "passed" : "failed");
	endtask

	initial begin
		rst_n = 1'b0;
		frame_data = '0;
		frame_valid = 1'b0;
		frame_last = 1'b0;
		frame_bytes = '0;
		cfg_strobe = 1'b0;
		cfg_index = '0;
		cfg_enable = 1'b0;
		cfg_word = '0;
		cfg_value = '0;
		cfg_mask = '0;
		log_id = '0;
		log_ready = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		start_test(); // scripts are all off after reset.
		repeat (6) send_frame();
		finish_test("disabled");

		start_test();
		for (int i = 0; i < `NUM_SCRIPTS; i++) random_script(i);
		repeat (20) send_frame();
		finish_test("match");

		start_test();
		write_script(0, 1'b1, 3, {$random(seed), $random(seed)}, '0);
		write_script(1, 1'b1, 34, '0, '0); // beyond the longest frame.
		write_script(2, 1'b0, 0, '0, '0);
		write_script(3, 1'b0, 0, '0, '0);
		repeat (10) send_frame();
		finish_test("mask");

		start_test();
		write_script(0, 1'b1, 0, '0, '0);
		ready_mode = 1;
		repeat (12) send_frame();
		repeat (STALL_CYCLES / 4) @(posedge clk);
		ready_mode = 0;
		assert (refused_cnt > ref_start) else begin
			$display("no frame was refused while the log was stalled");
			err_cnt++;
		end
		finish_test("backpressure");

		start_test();
		for (int f = 0; f < 12; f++) begin
			random_script(rand_below(`NUM_SCRIPTS));
			send_frame();
		end
		finish_test("reconfig");

		$display("%0d tests run, %0d failed, %0d errors in total", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/eth_logger_top.sv */
// logger top: capture, script matcher and log emitter joined over the summary interface
`timescale 1ns/1ps
`default_nettype none

`include "eth_logger_defines.svh"

module eth_logger_top (
	input wire clk,
	input wire rst_n,

	input wire [`LOG_WIDTH-1:0] frame_data,
	input wire frame_valid,
	input wire frame_last,
	input wire [2:0] frame_bytes,

	input wire cfg_strobe,
	input wire [$clog2(`NUM_SCRIPTS)-1:0] cfg_index,
	input wire cfg_enable,
	input wire [`CFG_WORD_BITS-1:0] cfg_word,
	input wire [`LOG_WIDTH-1:0] cfg_value,
	input wire [`LOG_WIDTH-1:0] cfg_mask,

	input wire [15:0] log_id,
	output logic [`LOG_WIDTH-1:0] log_data,
	output logic log_last,
	output logic log_valid,
	input wire log_ready
);
	logic match_strobe;
	logic [`NUM_SCRIPTS-1:0] match_flags;
	logic [`LOG_WIDTH-1:0] buf_data;
	logic buf_valid;
	logic buf_ready;

	frame_info_if info_i ();

	eth_frame_capture capture_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_data(frame_data),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_bytes(frame_bytes),
		.info(info_i.capture),
		.buf_data(buf_data),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready)
	);

	eth_script_matcher matcher_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_data(frame_data),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.cfg_strobe(cfg_strobe),
		.cfg_index(cfg_index),
		.cfg_enable(cfg_enable),
		.cfg_word(cfg_word),
		.cfg_value(cfg_value),
		.cfg_mask(cfg_mask),
		.match_strobe(match_strobe),
		.match_flags(match_flags)
	);

	eth_frame_log_emitter emitter_i (
		.clk(clk),
		.rst_n(rst_n),
		.log_id(log_id),
		.info(info_i.emitter),
		.match_strobe(match_strobe),
		.match_flags(match_flags),
		.buf_data(buf_data),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready),
		.log_data(log_data),
		.log_last(log_last),
		.log_valid(log_valid),
		.log_ready(log_ready)
	);

endmodule

`default_nettype wire

/* hw/eth_frame_log_emitter.sv */
// log emitter: summary queue, header build and frame forward or discard FSM
`timescale 1ns/1ps
`default_nettype none

`include "eth_logger_defines.svh"

module eth_frame_log_emitter (
	input wire clk,
	input wire rst_n,

	input wire [15:0] log_id,

	frame_info_if.emitter info,

	input wire match_strobe,
	input wire [`NUM_SCRIPTS-1:0] match_flags,

	input wire [`LOG_WIDTH-1:0] buf_data,
	input wire buf_valid,
	output logic buf_ready,

	output logic [`LOG_WIDTH-1:0] log_data,
	output logic log_last,
	output logic log_valid,
	input wire log_ready
);
	import eth_frame_pkg::*;
	import eth_log_pkg::*;

	localparam int Q_DEPTH = `INFO_FIFO_DEPTH;
	localparam int Q_BITS = $clog2(Q_DEPTH);
	localparam int CNT_BITS = $clog2(HDR_WORDS);

	enum logic [1:0] {ST_IDLE, ST_HEADER, ST_FRAME, ST_DROP} state;

	logic [`NUM_SCRIPTS-1:0] q_flags [Q_DEPTH];
	logic [15:0] q_size [Q_DEPTH];
	logic [63:0] q_ts [Q_DEPTH];
	logic [Q_BITS-1:0] q_wr;
	logic [Q_BITS-1:0] q_rd;
	logic [Q_BITS:0] q_cnt;
	logic q_push;
	logic q_pop;

	log_header_u hdr;
	logic [CNT_BITS-1:0] tx_cnt;
	logic [15:0] beats_left;
	logic beat_done;

	assign q_push = info.info_strobe && info.info_stored; // refused frames never queue.
	assign q_pop = (state == ST_IDLE) && (q_cnt != '0);
	assign beat_done = buf_valid && buf_ready;

	always_ff @(posedge clk) begin
		if (q_push) begin
			q_flags[q_wr] <= match_flags;
			q_size[q_wr] <= info.info_size;
			q_ts[q_wr] <= info.info_timestamp;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			q_wr <= '0;
			q_rd <= '0;
			q_cnt <= '0;
		end else begin
			if (q_push) begin
				q_wr <= q_wr + 1'b1;
			end
			if (q_pop) begin
				q_rd <= q_rd + 1'b1;
			end
			q_cnt <= q_cnt + (Q_BITS + 1)'(q_push) - (Q_BITS + 1)'(q_pop);

			case (state)
				ST_IDLE: begin
					if (q_pop) begin
						beats_left <= frame_beats(q_size[q_rd]);
						tx_cnt <= '0;
						if (q_flags[q_rd] != '0) begin
							hdr <= make_log_header(log_id, q_ts[q_rd], q_size[q_rd], q_flags[q_rd]);
							state <= ST_HEADER;
						end else begin
							state <= ST_DROP;
						end
					end
				end

				ST_HEADER: begin
					if (log_ready) begin
						hdr.words <= {{`LOG_WIDTH{1'b0}}, hdr.words[HDR_WORDS-1:1]};
						if (tx_cnt == CNT_BITS'(HDR_WORDS - 1)) begin
							state <= ST_FRAME;
						end else begin
							tx_cnt <= tx_cnt + 1'b1;
						end
					end
				end

				// frame and drop both walk the same word count.
				ST_FRAME, ST_DROP: begin
					if (beat_done) begin
						beats_left <= beats_left - 16'd1;
						if (beats_left == 16'd1) begin
							state <= ST_IDLE;
						end
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	always_comb begin
		log_data = '0;
		log_last = 1'b0;
		log_valid = 1'b0;
		buf_ready = 1'b0;
		case (state)
			ST_HEADER: begin
				log_data = hdr.words[0];
				log_valid = 1'b1;
			end
			ST_FRAME: begin
				log_data = buf_data;
				log_valid = buf_valid;
				log_last = (beats_left == 16'd1);
				buf_ready = log_ready;
			end
			ST_DROP: begin
				buf_ready = 1'b1; // discard as fast as words arrive.
			end
			default: begin
				log_valid = 1'b0;
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (!rst_n) info.info_strobe == match_strobe)
		else $error("capture and matcher strobes out of step");

	assert property (@(posedge clk) disable iff (!rst_n) q_push |-> (q_cnt < Q_DEPTH) || q_pop)
		else $error("summary queue overflow");

endmodule

`default_nettype wire

/* hw/eth_script_matcher.sv */
// script matcher: four configurable word/value/mask scripts checked against each frame
`timescale 1ns/1ps
`default_nettype none

`include "eth_logger_defines.svh"

module eth_script_matcher (
	input wire clk,
	input wire rst_n,

	input wire [`LOG_WIDTH-1:0] frame_data,
	input wire frame_valid,
	input wire frame_last,

	input wire cfg_strobe,
	input wire [$clog2(`NUM_SCRIPTS)-1:0] cfg_index,
	input wire cfg_enable,
	input wire [`CFG_WORD_BITS-1:0] cfg_word,
	input wire [`LOG_WIDTH-1:0] cfg_value,
	input wire [`LOG_WIDTH-1:0] cfg_mask,

	output logic match_strobe,
	output logic [`NUM_SCRIPTS-1:0] match_flags
);
	logic [`NUM_SCRIPTS-1:0] script_en;
	logic [`CFG_WORD_BITS-1:0] script_word [`NUM_SCRIPTS];
	logic [`LOG_WIDTH-1:0] script_value [`NUM_SCRIPTS];
	logic [`LOG_WIDTH-1:0] script_mask [`NUM_SCRIPTS];
	logic [`CFG_WORD_BITS-1:0] beat_idx;
	logic [`NUM_SCRIPTS-1:0] flags_acc;
	logic [`NUM_SCRIPTS-1:0] hit;

	// only masked bits take part in the compare.
	always_comb begin
		for (int i = 0; i < `NUM_SCRIPTS; i++) begin
			hit[i] = script_en[i] && (script_word[i] == beat_idx)
				&& (((frame_data ^ script_value[i]) & script_mask[i]) == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_strobe) begin
			script_word[cfg_index] <= cfg_word;
			script_value[cfg_index] <= cfg_value;
			script_mask[cfg_index] <= cfg_mask;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			script_en <= '0; // all scripts off.
			beat_idx <= '0;
			flags_acc <= '0;
			match_strobe <= 1'b0;
		end else begin
			if (cfg_strobe) begin
				script_en[cfg_index] <= cfg_enable;
			end
			match_strobe <= frame_valid && frame_last;
			if (frame_valid) begin
				if (frame_last) begin
					beat_idx <= '0;
					flags_acc <= '0;
				end else begin
					beat_idx <= beat_idx + 1'b1;
					flags_acc <= flags_acc | hit;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_valid && frame_last) begin
			match_flags <= flags_acc | hit; // includes the last beat.
		end
	end

endmodule

`default_nettype wire

/* hw/eth_frame_capture.sv */
// frame capture: cycle counter, admission check, byte count and the frame word buffer
`timescale 1ns/1ps
`default_nettype none

`include "eth_logger_defines.svh"

module eth_frame_capture (
	input wire clk,
	input wire rst_n,

	input wire [`LOG_WIDTH-1:0] frame_data,
	input wire frame_valid,
	input wire frame_last,
	input wire [2:0] frame_bytes,

	frame_info_if.capture info,

	output logic [`LOG_WIDTH-1:0] buf_data,
	output logic buf_valid,
	input wire buf_ready
);
	localparam int DEPTH = `DATA_FIFO_BEATS;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int MAX_BEATS = `MAX_FRAME_BYTES / `LOG_BYTES;
	// admit only when a frame of the largest size still fits.
	localparam logic [PTR_BITS:0] FILL_LIMIT = (PTR_BITS + 1)'(DEPTH - MAX_BEATS);

	logic [`LOG_WIDTH-1:0] mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] fill_cnt;
	logic [63:0] cyc_cnt;
	logic [63:0] ts_r;
	logic [15:0] byte_cnt;
	logic [15:0] bytes_before;
	logic [3:0] last_bytes;
	logic in_frame;
	logic admit_r;
	logic first_beat;
	logic admit;
	logic wr_en;
	logic rd_en;

	assign first_beat = frame_valid && !in_frame;
	assign admit = first_beat ? (fill_cnt <= FILL_LIMIT) : admit_r;
	assign wr_en = frame_valid && admit;
	assign rd_en = buf_valid && buf_ready;

	assign buf_valid = (fill_cnt != '0);
	assign buf_data = mem[rd_ptr];

	assign last_bytes = (frame_bytes == 3'd0) ? 4'(`LOG_BYTES) : {1'b0, frame_bytes};
	assign bytes_before = first_beat ? 16'd0 : byte_cnt; // count restarts on the first beat.

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= frame_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_cnt <= '0;
			cyc_cnt <= '0;
			in_frame <= 1'b0;
			admit_r <= 1'b0;
			info.info_strobe <= 1'b0;
		end else begin
			cyc_cnt <= cyc_cnt + 64'd1;
			info.info_strobe <= frame_valid && frame_last;
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			fill_cnt <= fill_cnt + (PTR_BITS + 1)'(wr_en) - (PTR_BITS + 1)'(rd_en);
			if (frame_valid) begin
				in_frame <= !frame_last;
				admit_r <= admit; // decision holds for the rest of the frame.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (first_beat) begin
			ts_r <= cyc_cnt;
		end
		if (frame_valid) begin
			if (frame_last) begin
				info.info_size <= bytes_before + 16'(last_bytes);
				info.info_timestamp <= first_beat ? cyc_cnt : ts_r;
				info.info_stored <= admit;
			end else begin
				byte_cnt <= bytes_before + 16'(`LOG_BYTES);
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> (fill_cnt < DEPTH))
		else $error("capture buffer written while full");

	assert property (@(posedge clk) disable iff (!rst_n)
			info.info_strobe |-> info.info_size inside {[`MIN_FRAME_BYTES:`MAX_FRAME_BYTES]})
		else $error("frame size %0d outside the promised range", info.info_size);

endmodule

`default_nettype wire

/* hw/frame_info_if.sv */
// per-frame summary from capture to emitter: strobe, size, timestamp, stored flag
`timescale 1ns/1ps
`default_nettype none

interface frame_info_if;
	logic info_strobe; // one cycle after the last beat.
	logic [15:0] info_size; // bytes.
	logic [63:0] info_timestamp;
	logic info_stored; // low when the buffer refused the frame.

	modport capture (
		output info_strobe, info_size, info_timestamp, info_stored
	);

	modport emitter (
		input info_strobe, info_size, info_timestamp, info_stored
	);
endinterface

`default_nettype wire

/* hw/eth_log_pkg.sv */
// log header union with field and word views, and the function that fills it
`default_nettype none

`include "eth_logger_defines.svh"

package eth_log_pkg;
	import eth_frame_pkg::*;

	localparam int HDR_WORDS = 3; // 24 bytes on the log stream.

	// fields listed from the top bit down, magic lands in word 0.
	typedef union packed {
		struct packed {
			logic [31-`NUM_SCRIPTS:0] pad;
			logic [`NUM_SCRIPTS-1:0] matched;
			logic [15:0] frame_size;
			logic [7:0] word_bytes;
			logic [7:0] direction;
			logic [63:0] timestamp;
			logic [15:0] record_len;
			logic [15:0] log_id;
			logic [31:0] magic;
		} fields;
		logic [HDR_WORDS-1:0][`LOG_WIDTH-1:0] words;
	} log_header_u;

	function automatic log_header_u make_log_header(input logic [15:0] log_id,
			input logic [63:0] timestamp, input logic [15:0] size,
			input logic [`NUM_SCRIPTS-1:0] flags);
		log_header_u hdr;
		hdr.fields.pad = '0;
		hdr.fields.matched = flags;
		hdr.fields.frame_size = size;
		hdr.fields.word_bytes = 8'(`LOG_BYTES);
		hdr.fields.direction = `DIRECTION_ID;
		hdr.fields.timestamp = timestamp;
		// header bytes beyond the first word, plus the padded frame.
		hdr.fields.record_len = 16'(HDR_WORDS * `LOG_BYTES - 8) + frame_size_ceil(size);
		hdr.fields.log_id = log_id;
		hdr.fields.magic = `LOG_MAGIC;
		return hdr;
	endfunction

endpackage

`default_nettype wire

/* hw/eth_frame_pkg.sv */
// frame size helpers: beats per frame and size rounded up to whole words
`default_nettype none

`include "eth_logger_defines.svh"

package eth_frame_pkg;

	// log2 of the bytes per word.
	localparam int unsigned BYTE_SHIFT = $clog2(`LOG_BYTES);

	// words a frame of the given byte size occupies.
	function automatic logic [15:0] frame_beats(input logic [15:0] size);
		logic [15:0] beats;
		beats = size >> BYTE_SHIFT;
		if (size[BYTE_SHIFT-1:0] != '0) begin
			beats = beats + 16'd1; // partial last word.
		end
		return beats;
	endfunction

	// byte size padded to a whole number of words.
	function automatic logic [15:0] frame_size_ceil(input logic [15:0] size);
		logic [15:0] beats;
		beats = frame_beats(size);
		return beats << BYTE_SHIFT;
	endfunction

endpackage

`default_nettype wire

/* include/eth_logger_defines.svh */
// word width, script count, frame size limits, buffer depths and log header constants
`ifndef ETH_LOGGER_DEFINES_SVH
`define ETH_LOGGER_DEFINES_SVH

// data path word, 8 bytes per beat.
`define LOG_WIDTH 64
`define LOG_BYTES (`LOG_WIDTH / 8)

// match scripts and the width of a script's word number.
`define NUM_SCRIPTS 4
`define CFG_WORD_BITS 8

// frame sizes the MAC side promises, in bytes.
`define MIN_FRAME_BYTES 64
`define MAX_FRAME_BYTES 256

// capture buffer, in words.
`define DATA_FIFO_BEATS 64

// summary queue in the emitter, one entry per stored frame.
`define INFO_FIFO_DEPTH 8

// fixed log header contents.
`define DIRECTION_ID 8'd65
`define LOG_MAGIC 32'h0242_5AFF

`endif
